// ==== colmix_sys.f ====
hw/colmix_pkg.sv
hw/layer_prio_mux.sv
hw/pixel_credit_fifo.sv
hw/palette_ram.sv
hw/color_out.sv
hw/colmix_top.sv
verif/colmix_chk.sv
verif/colmix_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the colour mixer testbench with Verilator
# exit status is the simulation's own status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module colmix_tb -Mdir obj_dir -f colmix_sys.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vcolmix_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// ==== verif/colmix_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour mixer testbench
// loads the palette, plays a table of layer pixels
// under random and held back-pressure, checks rgb
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module colmix_tb;
    import colmix_pkg::*;

    localparam int N_ROWS  = 24;
    localparam int RST_CYC = 5;
    localparam int LIMIT   = RST_CYC + 4096 + N_ROWS * 20 + 200;

    logic       clk;
    logic       rst;
    logic       in_valid;
    layer_pix_t in_pix;
    logic       in_ready;
    pal_wr_t    pal_wr;
    logic       out_valid;
    out_pix_t   out_pix;
    logic       out_ready;

    // stimulus table and expected outputs
    layer_pix_t stim [N_ROWS];
    out_pix_t   exp_tab [N_ROWS];
    out_pix_t   exp_q [$];
    // shadow of what was written to the palette
    pal_entry_t pal_model [4096];
    int         n_sent = 0;
    int         n_recv = 0;
    int         cycles = 0;
    logic       rand_on = 1'b0;
    logic       hold_low = 1'b0;

    colmix_top u_colmix_top (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_pix    (in_pix),
        .in_ready  (in_ready),
        .pal_wr    (pal_wr),
        .out_valid (out_valid),
        .out_pix   (out_pix),
        .out_ready (out_ready)
    );

    bind pixel_credit_fifo colmix_chk u_colmix_chk (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .pop        (pop),
        .credit_ret (credit_ret),
        .count      (count)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_pix(input string name, input out_pix_t got, input out_pix_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    // every bit of the address shows up somewhere in the entry
    function automatic pal_entry_t pal_pattern(input logic [11:0] a);
        pal_entry_t e;
        e.br = a[7:4] ^ {1'b0, a[11:9]};
        e.r  = a[3:0];
        e.g  = a[7:4] ^ a[3:0];
        e.b  = a[11:8] + a[3:0];
        return e;
    endfunction

    // first opaque layer, scroll 3 as last resort
    function automatic logic [11:0] ref_addr(input layer_pix_t p);
        if (p.obj[3:0] != 4'hf) return {3'd0, p.obj};
        if (p.scr1[3:0] != 4'hf) return {3'd1, p.scr1};
        if (p.scr2[3:0] != 4'hf) return {3'd2, p.scr2};
        return {3'd3, p.scr3};
    endfunction

    // c*17 minus a quarter and an eighth of c*(15-br)
    function automatic logic [7:0] ref_chan(input logic [3:0] c, input logic [3:0] br);
        int m;
        int v;
        m = (int'(c) * (15 - int'(br))) & 255;
        v = int'(c) * 17 - m / 4 - m / 8;
        return v[7:0];
    endfunction

    function automatic out_pix_t ref_out(input layer_pix_t p);
        pal_entry_t e;
        out_pix_t   o;
        e = pal_model[ref_addr(p)];
        o.blank = p.blank;
        o.rgb.red   = p.blank ? 8'd0 : ref_chan(e.r, e.br);
        o.rgb.green = p.blank ? 8'd0 : ref_chan(e.g, e.br);
        o.rgb.blue  = p.blank ? 8'd0 : ref_chan(e.b, e.br);
        return o;
    endfunction

    function automatic layer_pix_t make_row(input logic [8:0] o, input logic [8:0] s1,
                                            input logic [8:0] s2, input logic [8:0] s3,
                                            input logic bl);
        layer_pix_t p;
        p.obj   = o;
        p.scr1  = s1;
        p.scr2  = s2;
        p.scr3  = s3;
        p.blank = bl;
        return p;
    endfunction

    function automatic void fill_expected(input int lo, input int hi);
        for (int i = lo; i <= hi; i++) begin
            exp_tab[i] = ref_out(stim[i]);
        end
    endfunction

    task automatic write_entry(input logic [11:0] a, input pal_entry_t d);
        pal_wr_t w;
        w.we   = 1'b1;
        w.addr = a;
        w.data = d;
        pal_wr <= w;
        pal_model[a] = d;
        @(posedge clk);
    endtask

    // one row per acceptance, in_ready sampled at the edge
    task automatic apply_rows(input int lo, input int hi);
        for (int i = lo; i <= hi; i++) begin
            in_valid <= 1'b1;
            in_pix   <= stim[i];
            @(posedge clk);
            while (!in_ready) @(posedge clk);
            exp_q.push_back(exp_tab[i]);
            n_sent++;
        end
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (n_recv < n_sent && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        if (n_recv < n_sent) begin
            abort_run($sformatf("missing output: only %0d of %0d pixels arrived",
                                n_recv, n_sent));
        end
    endtask

    // in_ready must drop while the output is stalled
    task automatic stall_then_release();
        int waited;
        waited = 0;
        @(posedge clk);
        while (in_ready && waited < 60) begin
            @(posedge clk);
            waited++;
        end
        check_ready("in_ready", in_ready, 1'b0);
        repeat (10) @(posedge clk);
        hold_low <= 1'b0;
    endtask

    // output side, random or held stall
    always @(posedge clk) begin
        if (hold_low) begin
            out_ready <= 1'b0;
        end else if (rand_on) begin
            out_ready <= ($urandom % 4) != 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    // receiver, in-order compare
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("output pixel arrived with nothing pending");
            end else begin
                check_pix("out_pix", out_pix, exp_q.pop_front());
                n_recv++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            abort_run($sformatf("timeout: run still busy after %0d cycles", LIMIT));
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_pix    = '0;
        pal_wr    = '0;
        out_ready = 1'b1;
        void'($urandom(57964));

        // priority and brightness rows
        stim[0]  = make_row(9'h0f3, 9'h011, 9'h022, 9'h033, 1'b0);
        stim[1]  = make_row(9'h1ff, 9'h012, 9'h045, 9'h067, 1'b0);
        stim[2]  = make_row(9'h0af, 9'h03f, 9'h1a6, 9'h0b2, 1'b0);
        stim[3]  = make_row(9'h0ff, 9'h1cf, 9'h12f, 9'h0c9, 1'b0);
        // all transparent
        stim[4]  = make_row(9'h0ff, 9'h0ff, 9'h0ff, 9'h1ef, 1'b0);
        stim[5]  = make_row(9'h0f3, 9'h011, 9'h022, 9'h033, 1'b1);
        stim[6]  = make_row(9'h10c, 9'h0ff, 9'h0ff, 9'h0ff, 1'b0);
        stim[7]  = make_row(9'h0ff, 9'h0e7, 9'h05a, 9'h05b, 1'b0);
        // back-pressure burst
        stim[8]  = make_row(9'h05d, 9'h0ff, 9'h0ff, 9'h0ff, 1'b0);
        stim[9]  = make_row(9'h1ff, 9'h166, 9'h0ff, 9'h0ff, 1'b0);
        stim[10] = make_row(9'h0ff, 9'h0ff, 9'h171, 9'h0ff, 1'b1);
        stim[11] = make_row(9'h0ff, 9'h0ff, 9'h0ff, 9'h184, 1'b0);
        stim[12] = make_row(9'h092, 9'h093, 9'h094, 9'h095, 1'b0);
        stim[13] = make_row(9'h0af, 9'h0b8, 9'h0c9, 9'h0da, 1'b0);
        stim[14] = make_row(9'h1bf, 9'h0cf, 9'h0d7, 9'h0e8, 1'b0);
        stim[15] = make_row(9'h0ff, 9'h0ff, 9'h0ff, 9'h0ff, 1'b1);
        // after the rewrite, 16..19 reuse rows 0, 1, 2, 4
        stim[16] = stim[0];
        stim[17] = stim[1];
        stim[18] = stim[2];
        stim[19] = stim[4];
        stim[20] = make_row(9'h0e1, 9'h0ff, 9'h0ff, 9'h0ff, 1'b0);
        stim[21] = make_row(9'h0ff, 9'h0f8, 9'h0ff, 9'h0ff, 1'b0);
        stim[22] = make_row(9'h1ff, 9'h1ff, 9'h13c, 9'h0ff, 1'b0);
        stim[23] = make_row(9'h0ff, 9'h0ff, 9'h0ff, 9'h1f0, 1'b0);

        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_ready("in_ready", in_ready, 1'b1);
        check_ready("out_valid", out_valid, 1'b0);

        for (int a = 0; a < 4096; a++) begin
            write_entry(12'(a), pal_pattern(12'(a)));
        end
        pal_wr <= '0;
        fill_expected(0, N_ROWS - 1);

        rand_on <= 1'b1;
        apply_rows(0, 7);
        wait_drain();

        hold_low <= 1'b1;
        fork
            apply_rows(8, 15);
            stall_then_release();
        join
        wait_drain();

        // idle input, new colours for four entries
        for (int k = 16; k <= 19; k++) begin
            write_entry(ref_addr(stim[k]), pal_entry_t'(pal_pattern(ref_addr(stim[k])) ^ 16'h7777));
        end
        pal_wr <= '0;
        @(posedge clk);
        fill_expected(16, 19);
        apply_rows(16, N_ROWS - 1);
        wait_drain();

        if (n_recv == N_ROWS && exp_q.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run($sformatf("end of run with %0d of %0d pixels matched", n_recv, N_ROWS));
        end
    end

endmodule

// ==== verif/colmix_chk.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// credit FIFO checker
// occupancy and credit-return rules of the FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module colmix_chk (
    input logic                          clk,
    input logic                          rst,
    input logic                          push,
    input logic                          pop,
    input logic                          credit_ret,
    input logic [colmix_pkg::CRED_W-1:0] count
);
    import colmix_pkg::*;

    // occupancy bounded by the credit pool
    count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CRED_W'(FIFO_DEPTH)) else $error("FIFO count above depth");

    pop_not_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> count != '0) else $error("FIFO popped while empty");

    // one credit back, one cycle after the pop
    credit_after_pop: assert property (@(posedge clk) disable iff (rst)
        pop |=> credit_ret) else $error("no credit return after pop");

    push_not_full: assert property (@(posedge clk) disable iff (rst)
        push |-> count != CRED_W'(FIFO_DEPTH)) else $error("FIFO pushed while full");

endmodule

// ==== hw/colmix_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour mixer top
// priority mux, credit FIFO, palette and output
// stage wired into one back-pressured pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module colmix_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  colmix_pkg::layer_pix_t in_pix,
    output logic                   in_ready,
    input  colmix_pkg::pal_wr_t    pal_wr,
    output logic                   out_valid,
    output colmix_pkg::out_pix_t   out_pix,
    input  logic                   out_ready
);
    import colmix_pkg::*;

    // mux to FIFO
    logic              push;
    mix_pix_t          push_pix;
    logic              credit_ret;
    // FIFO to output stage
    logic              pop;
    mix_pix_t          head_pix;
    logic              not_empty;
    // palette read port
    logic              rd_en;
    logic [PAL_AW-1:0] rd_addr;
    pal_entry_t        rd_data;

    layer_prio_mux u_layer_prio_mux (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_pix     (in_pix),
        .in_ready   (in_ready),
        .push       (push),
        .push_pix   (push_pix),
        .credit_ret (credit_ret)
    );

    pixel_credit_fifo u_pixel_credit_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_pix   (push_pix),
        .pop        (pop),
        .head_pix   (head_pix),
        .not_empty  (not_empty),
        .credit_ret (credit_ret)
    );

    palette_ram u_palette_ram (
        .clk     (clk),
        .pal_wr  (pal_wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    color_out u_color_out (
        .clk       (clk),
        .rst       (rst),
        .head_pix  (head_pix),
        .not_empty (not_empty),
        .pop       (pop),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .out_valid (out_valid),
        .out_pix   (out_pix),
        .out_ready (out_ready)
    );

endmodule

// ==== hw/color_out.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour output stage
// pops pixels, looks up the palette, applies the
// brightness scale and blanking, honours out_ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module color_out (
    input  logic                          clk,
    input  logic                          rst,
    input  colmix_pkg::mix_pix_t          head_pix,
    input  logic                          not_empty,
    output logic                          pop,
    output logic                          rd_en,
    output logic [colmix_pkg::PAL_AW-1:0] rd_addr,
    input  colmix_pkg::pal_entry_t        rd_data,
    output logic                          out_valid,
    output colmix_pkg::out_pix_t          out_pix,
    input  logic                          out_ready
);
    import colmix_pkg::*;

    // stage 1 is the palette read, its data sits in the RAM register
    logic     s1_valid;
    logic     s1_blank;
    logic     s1_adv;
    logic     s2_adv;
    out_pix_t scaled;

    // c*17 less up to a third of it as brightness drops
    function automatic logic [7:0] scale(input logic [3:0] c, input logic [3:0] br);
        logic [7:0] m;
        m = {4'd0, c} * {4'd0, 4'hf - br};
        return {c, c} - (m >> 2) - (m >> 3);
    endfunction

    // stage 2 is free or draining
    assign s2_adv = !out_valid || out_ready;
    // stage 1 is free or moving into stage 2
    assign s1_adv = !s1_valid || s2_adv;

    assign pop     = not_empty && s1_adv;
    // read only on a pop so rd_data holds across stalls
    assign rd_en   = pop;
    assign rd_addr = head_pix.pal_addr;

    always_comb begin
        scaled.blank = s1_blank;
        if (s1_blank) begin
            // black during blanking
            scaled.rgb = '0;
        end else begin
            scaled.rgb.red   = scale(rd_data.r, rd_data.br);
            scaled.rgb.green = scale(rd_data.g, rd_data.br);
            scaled.rgb.blue  = scale(rd_data.b, rd_data.br);
        end
    end

    // stage valid bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (s1_adv) begin
                s1_valid <= pop;
            end
            if (s2_adv) begin
                out_valid <= s1_valid;
            end
        end
    end

    // blank travels beside the palette read
    always_ff @(posedge clk) begin
        if (pop) begin
            s1_blank <= head_pix.blank;
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (s2_adv && s1_valid) begin
            out_pix <= scaled;
        end
    end

endmodule

// ==== hw/palette_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// palette RAM
// 4096 x 16 colour table, synchronous write and
// a registered read that holds while stalled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module palette_ram (
    input  logic                          clk,
    input  colmix_pkg::pal_wr_t           pal_wr,
    input  logic                          rd_en,
    input  logic [colmix_pkg::PAL_AW-1:0] rd_addr,
    output colmix_pkg::pal_entry_t        rd_data
);
    import colmix_pkg::*;

    // contents undefined until loaded
    pal_entry_t mem [2**PAL_AW];

    // load port
    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            mem[pal_wr.addr] <= pal_wr.data;
        end
    end

    // read register
    // old data on a same-cycle write to the same address
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== hw/pixel_credit_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel credit FIFO
// circular buffer of mixed pixels between the mux
// and the output stage, one credit back per pop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pixel_credit_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  colmix_pkg::mix_pix_t push_pix,
    input  logic                 pop,
    output colmix_pkg::mix_pix_t head_pix,
    output logic                 not_empty,
    output logic                 credit_ret
);
    import colmix_pkg::*;

    typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;

    mix_pix_t          mem [FIFO_DEPTH];
    ptr_t              wr_ptr;
    ptr_t              rd_ptr;
    // occupancy from 0 to FIFO_DEPTH
    logic [CRED_W-1:0] count;

    // head shown straight from storage
    assign head_pix  = mem[rd_ptr];
    assign not_empty = (count != '0);

    // storage write
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_pix;
        end
    end

    // pointers wrap at FIFO_DEPTH
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == ptr_t'(FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == ptr_t'(FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // push and pop together leave the count alone
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // credit back to the producer the cycle after a pop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= pop;
        end
    end

endmodule

// ==== hw/layer_prio_mux.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// layer priority mux
// picks the front-most opaque layer, forms the
// palette address and pushes it against credits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module layer_prio_mux (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  colmix_pkg::layer_pix_t in_pix,
    output logic                   in_ready,
    output logic                   push,
    output colmix_pkg::mix_pix_t   push_pix,
    input  logic                   credit_ret
);
    import colmix_pkg::*;

    logic [CRED_W-1:0] credits;
    logic              accept;
    logic [2:0]        sel_code;
    logic [PXL_W-1:0]  sel_pix;
    mix_pix_t          mixed;

    // fixed order sprite, scroll 1, scroll 2, scroll 3
    always_comb begin
        if (in_pix.obj[3:0] != TRANSP) begin
            sel_code = LYR_OBJ;
            sel_pix  = in_pix.obj;
        end else if (in_pix.scr1[3:0] != TRANSP) begin
            sel_code = LYR_SCR1;
            sel_pix  = in_pix.scr1;
        end else if (in_pix.scr2[3:0] != TRANSP) begin
            sel_code = LYR_SCR2;
            sel_pix  = in_pix.scr2;
        end else begin
            // scroll 3 wins even when transparent
            sel_code = LYR_SCR3;
            sel_pix  = in_pix.scr3;
        end
        mixed.pal_addr = {sel_code, sel_pix};
        mixed.blank    = in_pix.blank;
    end

    // ready only with a free FIFO slot guaranteed
    assign in_ready = (credits != '0);
    assign accept   = in_valid && in_ready;

    // spend on accept, refund on return, both may coincide
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= CRED_W'(FIFO_DEPTH);
        end else begin
            case ({accept, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // push strobe one cycle after acceptance
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            push <= 1'b0;
        end else begin
            push <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            push_pix <= mixed;
        end
    end

endmodule

// ==== hw/colmix_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour mixer package
// widths, layer codes and the packed types shared
// by the priority, FIFO, palette and output blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package colmix_pkg;

    // one layer pixel, colour index in the low nibble
    localparam int PXL_W = 9;
    // palette address is layer code plus pixel
    localparam int PAL_AW = 12;
    // low nibble of all ones means see-through
    localparam logic [3:0] TRANSP = 4'd15;

    // FIFO entries, one credit each
    localparam int FIFO_DEPTH = 4;
    // holds 0 .. FIFO_DEPTH
    localparam int CRED_W = 3;

    // layer codes, upper palette address bits
    localparam logic [2:0] LYR_OBJ  = 3'd0;
    localparam logic [2:0] LYR_SCR1 = 3'd1;
    localparam logic [2:0] LYR_SCR2 = 3'd2;
    localparam logic [2:0] LYR_SCR3 = 3'd3;

    // four layer pixels of one slot
    typedef struct packed {
        logic [PXL_W-1:0] obj;
        logic [PXL_W-1:0] scr1;
        logic [PXL_W-1:0] scr2;
        logic [PXL_W-1:0] scr3;
        // horizontal or vertical blanking
        logic             blank;
    } layer_pix_t;

    // winning layer as palette address
    typedef struct packed {
        logic [PAL_AW-1:0] pal_addr;
        logic              blank;
    } mix_pix_t;

    // palette word, brightness in the top nibble
    typedef struct packed {
        logic [3:0] br;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } pal_entry_t;

    // palette load port
    typedef struct packed {
        logic              we;
        logic [PAL_AW-1:0] addr;
        pal_entry_t        data;
    } pal_wr_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        rgb_t rgb;
        logic blank;
    } out_pix_t;

endpackage
